/* build.f */
+incdir+sim
hw/rt_math_pkg.sv
hw/rt_scene_pkg.sv
hw/fx_divider.sv
hw/scene_buffer.sv
hw/ray_intersector.sv
hw/ray_reflector.sv
hw/ray_tracer.sv
hw/rt_core.sv
sim/tb_clock_gen.sv
sim/rt_core_tb.sv

/* hw/fx_divider.sv */
`timescale 1ns/1ns

module fx_divider import rt_math_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  fx24_t dividend,
  input  fx24_t divisor,
  output fx24_t quotient,
  output logic  done
);

  localparam int STEPS = 40;

  logic        busy;
  logic [5:0]  step;
  // Shifted dividend, quotient bits enter at the bottom
  logic [39:0] num;
  logic [23:0] rem;
  logic [23:0] dvs;
  logic        neg;

  logic [23:0] dividend_mag;
  logic [23:0] divisor_mag;
  logic [24:0] rem_shift;
  logic        rem_ge;
  fx24_t       quot_sat;

  always_comb begin
    dividend_mag = dividend[23] ? 24'(-dividend) : dividend;
    divisor_mag = divisor[23] ? 24'(-divisor) : divisor;
    rem_shift = {rem, num[39]};
    rem_ge = rem_shift >= {1'b0, dvs};
    // Clamp to the largest magnitude of the result sign
    if (neg) begin
      quot_sat = (num > 40'h800000) ? 24'sh800000 : -num[23:0];
    end else begin
      quot_sat = (num > 40'h7fffff) ? 24'sh7fffff : num[23:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      step <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        if (step == 6'(STEPS)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          step <= step + 6'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      num <= {dividend_mag, 16'd0};
      rem <= '0;
      dvs <= divisor_mag;
      neg <= dividend[23] ^ divisor[23];
    end else if (busy && step != 6'(STEPS)) begin
      // One restoring step per cycle
      rem <= rem_ge ? 24'(rem_shift - {1'b0, dvs}) : rem_shift[23:0];
      num <= {num[38:0], rem_ge};
    end
    if (busy && step == 6'(STEPS)) begin
      quotient <= quot_sat;
    end
  end

  assert property (@(posedge clk) disable iff (rst) start |-> !busy)
    else $error("fx_divider: start while a division is running");

  assert property (@(posedge clk) disable iff (rst) start |-> divisor != '0)
    else $error("fx_divider: zero divisor at start");

endmodule

/* hw/ray_intersector.sv */
`timescale 1ns/1ns

module ray_intersector import rt_math_pkg::*, rt_scene_pkg::*; #(
  parameter  int NUM_OBJECTS = 4,
  localparam int IDX_W = (NUM_OBJECTS > 1) ? $clog2(NUM_OBJECTS) : 1
) (
  input  logic             clk,
  input  logic             rst,
  input  fx24_vec3         ray_origin,
  input  fx24_vec3         ray_dir,
  input  logic             ray_valid,
  output logic [IDX_W-1:0] obj_index,
  input  scene_object_t    obj,
  output hit_result_t      hit,
  output logic             hit_valid
);

  typedef enum logic [1:0] {IDLE, FETCH, DIVIDE, POSITION} intx_state_t;

  intx_state_t state;
  fx24_t       best_offset;

  fx24_t    dir_comp;
  fx24_t    org_comp;
  logic     last_obj;
  logic     take_hit;
  fx24_vec3 pos_calc;

  logic  div_start;
  fx24_t div_dividend;
  fx24_t div_quot;
  logic  div_done;

  always_comb begin
    dir_comp = fx_vec_get(ray_dir, obj.axis);
    org_comp = fx_vec_get(ray_origin, obj.axis);
    // Planes parallel to the ray are skipped without a divide
    div_start = (state == FETCH) && (dir_comp != '0);
    div_dividend = obj.offset - org_comp;
    last_obj = obj_index == IDX_W'(NUM_OBJECTS - 1);
    // Strict compare so the lowest index wins a tie
    take_hit = (div_quot >= FX_T_MIN) && (!hit.hit_any || div_quot < hit.t);
    pos_calc.x = (hit.axis == 2'd0) ? best_offset : ray_origin.x + fx_mul(ray_dir.x, hit.t);
    pos_calc.y = (hit.axis == 2'd1) ? best_offset : ray_origin.y + fx_mul(ray_dir.y, hit.t);
    pos_calc.z = (hit.axis == 2'd0 || hit.axis == 2'd1) ?
                 ray_origin.z + fx_mul(ray_dir.z, hit.t) : best_offset;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      obj_index <= '0;
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            obj_index <= '0;
            state <= FETCH;
          end
        end
        FETCH: begin
          if (dir_comp != '0) begin
            state <= DIVIDE;
          end else if (last_obj) begin
            state <= POSITION;
          end else begin
            obj_index <= obj_index + 1'b1;
          end
        end
        DIVIDE: begin
          if (div_done) begin
            if (last_obj) begin
              state <= POSITION;
            end else begin
              obj_index <= obj_index + 1'b1;
              state <= FETCH;
            end
          end
        end
        POSITION: begin
          hit_valid <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Result record, stable from hit_valid until the next start
  always_ff @(posedge clk) begin
    if (state == IDLE && ray_valid) begin
      hit.hit_any <= 1'b0;
    end
    if (state == DIVIDE && div_done && take_hit) begin
      hit.hit_any <= 1'b1;
      hit.axis <= obj.axis;
      hit.t <= div_quot;
      hit.mat <= obj.mat;
      best_offset <= obj.offset;
    end
    if (state == POSITION && hit.hit_any) begin
      hit.pos <= pos_calc;
    end
  end

  fx_divider u_div (
    .clk      (clk),
    .rst      (rst),
    .start    (div_start),
    .dividend (div_dividend),
    .divisor  (dir_comp),
    .quotient (div_quot),
    .done     (div_done)
  );

  assert property (@(posedge clk) disable iff (rst) !(hit_valid && ray_valid))
    else $error("ray_intersector: new ray started on the hit_valid cycle");

endmodule

/* hw/ray_reflector.sv */
`timescale 1ns/1ns

module ray_reflector import rt_math_pkg::*, rt_scene_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  fx24_vec3    ray_dir,
  input  fx24_vec3    ray_color,
  input  fx24_vec3    income_light,
  input  hit_result_t hit,
  input  logic        hit_valid,
  output fx24_vec3    new_dir,
  output fx24_vec3    new_origin,
  output fx24_vec3    new_color,
  output fx24_vec3    new_income_light,
  output logic        reflect_done
);

  fx24_vec3 mirrored;
  fx24_vec3 emitted;

  always_comb begin
    // Perfect mirror, flip the component along the plane normal
    mirrored = ray_dir;
    case (hit.axis)
      2'd0: mirrored.x = -ray_dir.x;
      2'd1: mirrored.y = -ray_dir.y;
      default: mirrored.z = -ray_dir.z;
    endcase
    emitted = fx_vec_mul(ray_color, hit.mat.emission);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      reflect_done <= 1'b0;
    end else begin
      reflect_done <= hit_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_valid) begin
      new_dir <= mirrored;
      new_origin <= hit.pos;
      new_color <= fx_vec_mul(ray_color, hit.mat.albedo);
      new_income_light.x <= income_light.x + emitted.x;
      new_income_light.y <= income_light.y + emitted.y;
      new_income_light.z <= income_light.z + emitted.z;
    end
  end

  assert property (@(posedge clk) disable iff (rst) hit_valid |-> hit.hit_any)
    else $error("ray_reflector: started on a miss");

endmodule

/* hw/ray_tracer.sv */
`timescale 1ns/1ns

module ray_tracer import rt_math_pkg::*, rt_scene_pkg::*; #(
  parameter  int NUM_OBJECTS = 4,
  parameter  int MAX_BOUNCES = 3,
  localparam int IDX_W = (NUM_OBJECTS > 1) ? $clog2(NUM_OBJECTS) : 1,
  localparam int BC_W = (MAX_BOUNCES > 1) ? $clog2(MAX_BOUNCES) : 1
) (
  input  logic             clk,
  input  logic             rst,
  input  fx24_vec3         ray_origin,
  input  fx24_vec3         ray_dir,
  input  logic             ray_valid,
  input  pixel_h_t         pixel_h_in,
  input  pixel_v_t         pixel_v_in,
  output logic [IDX_W-1:0] obj_index,
  input  scene_object_t    obj,
  output logic             ray_done,
  output fx24_vec3         pixel_color,
  output pixel_h_t         pixel_h_out,
  output pixel_v_t         pixel_v_out
);

  typedef enum logic [1:0] {IDLE, INTX, REFLECT} tracer_state_t;

  tracer_state_t   state;
  logic [BC_W-1:0] bounce_count;
  logic            intx_start;

  // Current ray
  fx24_vec3 cur_origin;
  fx24_vec3 cur_dir;
  fx24_vec3 cur_color;
  fx24_vec3 cur_light;

  hit_result_t intx_hit;
  logic        intx_hit_valid;
  logic        rflx_start;

  fx24_vec3 rflx_dir;
  fx24_vec3 rflx_origin;
  fx24_vec3 rflx_color;
  fx24_vec3 rflx_light;
  logic     rflx_done;

  // only a real hit goes on to the reflector
  assign rflx_start = intx_hit_valid && intx_hit.hit_any;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      bounce_count <= '0;
      intx_start <= 1'b0;
      ray_done <= 1'b0;
    end else begin
      intx_start <= 1'b0;
      ray_done <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            bounce_count <= '0;
            intx_start <= 1'b1;
            state <= INTX;
          end
        end
        INTX: begin
          if (intx_hit_valid) begin
            if (intx_hit.hit_any) begin
              state <= REFLECT;
            end else begin
              ray_done <= 1'b1;
              state <= IDLE;
            end
          end
        end
        REFLECT: begin
          if (rflx_done) begin
            if (bounce_count == BC_W'(MAX_BOUNCES - 1)) begin
              ray_done <= 1'b1;
              state <= IDLE;
            end else begin
              bounce_count <= bounce_count + 1'b1;
              intx_start <= 1'b1;
              state <= INTX;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && ray_valid) begin
      cur_origin <= ray_origin;
      cur_dir <= ray_dir;
      cur_color <= '{x: FX_ONE, y: FX_ONE, z: FX_ONE};
      cur_light <= '0;
      pixel_h_out <= pixel_h_in;
      pixel_v_out <= pixel_v_in;
    end
    if (state == INTX && intx_hit_valid && !intx_hit.hit_any) begin
      pixel_color <= cur_light;
    end
    if (state == REFLECT && rflx_done) begin
      cur_origin <= rflx_origin;
      cur_dir <= rflx_dir;
      cur_color <= rflx_color;
      cur_light <= rflx_light;
      pixel_color <= rflx_light;
    end
  end

  ray_intersector #(
    .NUM_OBJECTS (NUM_OBJECTS)
  ) u_intx (
    .clk        (clk),
    .rst        (rst),
    .ray_origin (cur_origin),
    .ray_dir    (cur_dir),
    .ray_valid  (intx_start),
    .obj_index  (obj_index),
    .obj        (obj),
    .hit        (intx_hit),
    .hit_valid  (intx_hit_valid)
  );

  ray_reflector u_rflx (
    .clk              (clk),
    .rst              (rst),
    .ray_dir          (cur_dir),
    .ray_color        (cur_color),
    .income_light     (cur_light),
    .hit              (intx_hit),
    .hit_valid        (rflx_start),
    .new_dir          (rflx_dir),
    .new_origin       (rflx_origin),
    .new_color        (rflx_color),
    .new_income_light (rflx_light),
    .reflect_done     (rflx_done)
  );

  assert property (@(posedge clk) disable iff (rst) ray_valid |-> state == IDLE)
    else $warning("ray_tracer: ray_valid ignored while a ray is traced");

endmodule

/* hw/rt_core.sv */
`timescale 1ns/1ns

module rt_core import rt_math_pkg::*, rt_scene_pkg::*; #(
  parameter  int NUM_OBJECTS = 4,
  parameter  int MAX_BOUNCES = 3,
  localparam int IDX_W = (NUM_OBJECTS > 1) ? $clog2(NUM_OBJECTS) : 1
) (
  input  logic             clk,
  input  logic             rst,
  // Scene load
  input  logic             scene_we,
  input  logic [IDX_W-1:0] scene_waddr,
  input  scene_object_t    scene_wdata,
  // Ray entry
  input  fx24_vec3         ray_origin,
  input  fx24_vec3         ray_dir,
  input  logic             ray_valid,
  input  pixel_h_t         pixel_h_in,
  input  pixel_v_t         pixel_v_in,
  // Pixel result
  output logic             ray_done,
  output fx24_vec3         pixel_color,
  output pixel_h_t         pixel_h_out,
  output pixel_v_t         pixel_v_out
);

  logic [IDX_W-1:0] obj_index;
  scene_object_t    obj;

  scene_buffer #(
    .NUM_OBJECTS (NUM_OBJECTS)
  ) u_scene (
    .clk         (clk),
    .rst         (rst),
    .scene_we    (scene_we),
    .scene_waddr (scene_waddr),
    .scene_wdata (scene_wdata),
    .obj_index   (obj_index),
    .obj         (obj)
  );

  ray_tracer #(
    .NUM_OBJECTS (NUM_OBJECTS),
    .MAX_BOUNCES (MAX_BOUNCES)
  ) u_tracer (
    .clk         (clk),
    .rst         (rst),
    .ray_origin  (ray_origin),
    .ray_dir     (ray_dir),
    .ray_valid   (ray_valid),
    .pixel_h_in  (pixel_h_in),
    .pixel_v_in  (pixel_v_in),
    .obj_index   (obj_index),
    .obj         (obj),
    .ray_done    (ray_done),
    .pixel_color (pixel_color),
    .pixel_h_out (pixel_h_out),
    .pixel_v_out (pixel_v_out)
  );

endmodule

/* hw/rt_math_pkg.sv */
package rt_math_pkg;

  // Signed fixed point, 8 integer and 16 fraction bits
  typedef logic signed [23:0] fx24_t;

  // Also used for colours as r, g, b in x, y, z
  typedef struct packed {
    fx24_t x;
    fx24_t y;
    fx24_t z;
  } fx24_vec3;

  // Plane axis: 0 = x, 1 = y, 2 = z
  typedef logic [1:0] axis_t;

  localparam fx24_t FX_ONE = 24'sh010000;
  // Keeps a ray from hitting the plane it just left
  localparam fx24_t FX_T_MIN = 24'sh000100;

  function automatic fx24_t fx_mul(fx24_t a, fx24_t b);
    logic signed [47:0] prod;
    logic signed [47:0] shifted;
    prod = a * b;
    shifted = prod >>> 16;
    return shifted[23:0];
  endfunction

  function automatic fx24_vec3 fx_vec_mul(fx24_vec3 a, fx24_vec3 b);
    fx24_vec3 r;
    r.x = fx_mul(a.x, b.x);
    r.y = fx_mul(a.y, b.y);
    r.z = fx_mul(a.z, b.z);
    return r;
  endfunction

  // Axis code 3 falls back to z
  function automatic fx24_t fx_vec_get(fx24_vec3 v, axis_t a);
    case (a)
      2'd0: return v.x;
      2'd1: return v.y;
      default: return v.z;
    endcase
  endfunction

endpackage

/* hw/rt_scene_pkg.sv */
package rt_scene_pkg;

  import rt_math_pkg::*;

  // Surface response, both as rgb in fixed point
  typedef struct packed {
    fx24_vec3 albedo;
    fx24_vec3 emission;
  } material_t;

  // Axis-aligned plane at offset along axis
  typedef struct packed {
    axis_t     axis;
    fx24_t     offset;
    material_t mat;
  } scene_object_t;

  // Nearest hit of one intersect pass
  typedef struct packed {
    logic      hit_any;
    axis_t     axis;
    fx24_t     t;
    fx24_vec3  pos;
    material_t mat;
  } hit_result_t;

  typedef logic [10:0] pixel_h_t;
  typedef logic [9:0]  pixel_v_t;

endpackage

/* hw/scene_buffer.sv */
`timescale 1ns/1ns

module scene_buffer import rt_scene_pkg::*; #(
  parameter  int NUM_OBJECTS = 4,
  localparam int IDX_W = (NUM_OBJECTS > 1) ? $clog2(NUM_OBJECTS) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 scene_we,
  input  logic [IDX_W-1:0]     scene_waddr,
  input  scene_object_t        scene_wdata,
  input  logic [IDX_W-1:0]     obj_index,
  output scene_object_t        obj
);

  scene_object_t objects [NUM_OBJECTS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_OBJECTS; i++) begin
        objects[i] <= '0;
      end
    end else if (scene_we) begin
      objects[scene_waddr] <= scene_wdata;
    end
  end

  // Same-cycle read for the intersector
  assign obj = objects[obj_index];

  assert property (@(posedge clk) disable iff (rst)
    scene_we |-> scene_waddr < NUM_OBJECTS)
    else $error("scene_buffer: write address out of range");

  assert property (@(posedge clk) disable iff (rst) obj_index < NUM_OBJECTS)
    else $error("scene_buffer: read index out of range");

endmodule

/* sim/rt_model.svh */
`ifndef RT_MODEL_SVH
`define RT_MODEL_SVH

// Reference copy of the scene, loaded into the DUT as well
scene_object_t model_scene [NUM_OBJECTS];

// Full product, arithmetic shift by 16, low 24 bits kept
function automatic fx24_t model_mul(fx24_t a, fx24_t b);
  longint p;
  p = longint'(a) * longint'(b);
  p = p >>> 16;
  return fx24_t'(p);
endfunction

// Quotient of (num << 16) / den, toward zero, clamped to 24 bits
function automatic fx24_t model_div(fx24_t num, fx24_t den);
  longint q;
  q = (longint'(num) * 65536) / longint'(den);
  if (q > 64'sd8388607) return 24'sh7fffff;
  if (q < -64'sd8388608) return 24'sh800000;
  return fx24_t'(q);
endfunction

function automatic fx24_t model_comp(fx24_vec3 v, axis_t a);
  case (a)
    2'd0: return v.x;
    2'd1: return v.y;
    default: return v.z;
  endcase
endfunction

// Light gathered by one ray over at most MAX_BOUNCES mirror hits
function automatic fx24_vec3 model_trace(fx24_vec3 origin, fx24_vec3 dir);
  fx24_vec3 org;
  fx24_vec3 d;
  fx24_vec3 color;
  fx24_vec3 light;
  fx24_vec3 pos;
  material_t mat;
  logic found;
  fx24_t best_t;
  fx24_t num;
  fx24_t dc;
  fx24_t t;
  int best_idx;
  org = origin;
  d = dir;
  color.x = FX_ONE;
  color.y = FX_ONE;
  color.z = FX_ONE;
  light = '0;
  for (int b = 0; b < MAX_BOUNCES; b++) begin
    found = 1'b0;
    best_t = '0;
    best_idx = 0;
    for (int i = 0; i < NUM_OBJECTS; i++) begin
      dc = model_comp(d, model_scene[i].axis);
      if (dc != '0) begin
        num = model_scene[i].offset - model_comp(org, model_scene[i].axis);
        t = model_div(num, dc);
        // Ties keep the earlier plane
        if (t >= FX_T_MIN && (!found || t < best_t)) begin
          found = 1'b1;
          best_t = t;
          best_idx = i;
        end
      end
    end
    if (!found) return light;
    pos.x = org.x + model_mul(d.x, best_t);
    pos.y = org.y + model_mul(d.y, best_t);
    pos.z = org.z + model_mul(d.z, best_t);
    mat = model_scene[best_idx].mat;
    case (model_scene[best_idx].axis)
      2'd0: begin pos.x = model_scene[best_idx].offset; d.x = -d.x; end
      2'd1: begin pos.y = model_scene[best_idx].offset; d.y = -d.y; end
      default: begin pos.z = model_scene[best_idx].offset; d.z = -d.z; end
    endcase
    light.x = light.x + model_mul(color.x, mat.emission.x);
    light.y = light.y + model_mul(color.y, mat.emission.y);
    light.z = light.z + model_mul(color.z, mat.emission.z);
    color.x = model_mul(color.x, mat.albedo.x);
    color.y = model_mul(color.y, mat.albedo.y);
    color.z = model_mul(color.z, mat.albedo.z);
    org = pos;
  end
  return light;
endfunction

`endif

/* sim/rt_core_tb.sv */
`timescale 1ns/1ns

module rt_core_tb import rt_math_pkg::*, rt_scene_pkg::*; ();

  localparam int NUM_OBJECTS = 4;
  localparam int MAX_BOUNCES = 3;
  localparam int IDX_W = $clog2(NUM_OBJECTS);
  localparam int CLK_PERIOD = 100;
  localparam int NUM_ROWS = 14;
  localparam int NUM_RANDOM = 6;
  localparam int IDLE_CYCLES = 8;
  localparam logic [31:0] RAND_SEED = 32'h4d39c222;
  localparam int WATCHDOG_CYCLES =
    2 * NUM_ROWS * (MAX_BOUNCES + 1) * (NUM_OBJECTS * 43 + 4);

  typedef struct packed {
    fx24_vec3 origin;
    fx24_vec3 dir;
    pixel_h_t h;
    pixel_v_t v;
    fx24_vec3 expected;
  } ray_row_t;

  logic             clk;
  logic             rst;
  logic             scene_we;
  logic [IDX_W-1:0] scene_waddr;
  scene_object_t    scene_wdata;
  fx24_vec3         ray_origin;
  fx24_vec3         ray_dir;
  logic             ray_valid;
  pixel_h_t         pixel_h_in;
  pixel_v_t         pixel_v_in;
  logic             ray_done;
  fx24_vec3         pixel_color;
  pixel_h_t         pixel_h_out;
  pixel_v_t         pixel_v_out;

  ray_row_t rows [NUM_ROWS];
  string    row_names [NUM_ROWS];
  int       row_count;
  int       pass_count;
  int       fail_count;

  `include "rt_model.svh"

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (4)
  ) u_clk (
    .clk (clk),
    .rst (rst)
  );

  rt_core #(
    .NUM_OBJECTS (NUM_OBJECTS),
    .MAX_BOUNCES (MAX_BOUNCES)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .scene_we    (scene_we),
    .scene_waddr (scene_waddr),
    .scene_wdata (scene_wdata),
    .ray_origin  (ray_origin),
    .ray_dir     (ray_dir),
    .ray_valid   (ray_valid),
    .pixel_h_in  (pixel_h_in),
    .pixel_v_in  (pixel_v_in),
    .ray_done    (ray_done),
    .pixel_color (pixel_color),
    .pixel_h_out (pixel_h_out),
    .pixel_v_out (pixel_v_out)
  );

  function automatic fx24_t to_fx(int n);
    return fx24_t'(n * 65536);
  endfunction

  function automatic fx24_vec3 make_vec(fx24_t x, fx24_t y, fx24_t z);
    fx24_vec3 v;
    v.x = x;
    v.y = y;
    v.z = z;
    return v;
  endfunction

  function automatic scene_object_t make_plane(axis_t axis, fx24_t offset,
                                               fx24_vec3 albedo, fx24_vec3 emission);
    scene_object_t p;
    p.axis = axis;
    p.offset = offset;
    p.mat.albedo = albedo;
    p.mat.emission = emission;
    return p;
  endfunction

  // Mostly -2 to 2, sometimes zero or a few LSBs to drive the divide into saturation
  function automatic fx24_t rand_comp();
    logic [31:0] r;
    logic signed [17:0] wide;
    logic signed [5:0] tiny;
    r = $urandom;
    wide = r[17:0];
    tiny = r[23:18];
    case (r[31:29])
      3'd0: return '0;
      3'd1: return tiny;
      default: return wide;
    endcase
  endfunction

  task automatic build_scene();
    fx24_vec3 half;
    half = make_vec(24'sh008000, 24'sh008000, 24'sh008000);
    // Facing mirrors on x, an emitter on y, a back wall on z
    model_scene[0] = make_plane(2'd0, to_fx(4), half,
                                make_vec(24'sh001000, 24'sh002000, 24'sh000800));
    model_scene[1] = make_plane(2'd0, to_fx(-4), half,
                                make_vec(24'sh000800, 24'sh001000, 24'sh002000));
    model_scene[2] = make_plane(2'd1, to_fx(8), '0,
                                make_vec(FX_ONE, 24'sh00c000, 24'sh008000));
    model_scene[3] = make_plane(2'd2, to_fx(-2),
                                make_vec(24'sh004000, 24'sh008000, 24'sh00c000),
                                make_vec(24'sh000400, 24'sh000400, 24'sh000400));
  endtask

  task automatic add_row(input string name, input fx24_vec3 origin, input fx24_vec3 dir);
    ray_row_t row;
    row.origin = origin;
    row.dir = dir;
    row.h = pixel_h_t'(row_count * 37 + 5);
    row.v = pixel_v_t'(row_count * 19 + 3);
    row.expected = model_trace(origin, dir);
    rows[row_count] = row;
    row_names[row_count] = name;
    row_count++;
  endtask

  task automatic build_table();
    fx24_vec3 zero;
    fx24_t rx;
    fx24_t ry;
    fx24_t rz;
    zero = '0;
    add_row("away_from_scene", zero, make_vec(0, 0, to_fx(1)));
    add_row("emissive_hit", zero, make_vec(0, to_fx(1), 0));
    add_row("mirror_bounce", zero, make_vec(to_fx(1), 0, 0));
    add_row("nearest_x", zero, make_vec(to_fx(1), 24'sh008000, 0));
    add_row("nearest_y", zero, make_vec(24'sh004000, to_fx(1), 0));
    add_row("nearest_z", zero, make_vec(24'sh008000, 24'sh008000, to_fx(-1)));
    add_row("tie_saturate", zero, make_vec(0, 24'sh000001, -24'sh000001));
    add_row("offset_origin", make_vec(to_fx(1), to_fx(-2), 24'sh008000),
            make_vec(to_fx(-1), 24'sh008000, 24'sh004000));
    for (int k = 0; k < NUM_RANDOM; k++) begin
      rx = rand_comp();
      ry = rand_comp();
      rz = rand_comp();
      add_row($sformatf("random_%0d", k), zero, make_vec(rx, ry, rz));
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      pass_count++;
      $display("[pass] %s", name);
    end else begin
      fail_count++;
      $display("[fail] %s (%0d mismatches)", name, errs);
    end
  endtask

  task automatic check_idle_after_reset();
    int errs;
    errs = 0;
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      assert (ray_done === 1'b0) else begin
        $display("ray_done went high after reset although no ray was given");
        errs++;
      end
    end
    report_test("idle_after_reset", errs);
  endtask

  task automatic load_scene();
    for (int i = 0; i < NUM_OBJECTS; i++) begin
      scene_we <= 1'b1;
      scene_waddr <= IDX_W'(i);
      scene_wdata <= model_scene[i];
      @(posedge clk);
    end
    scene_we <= 1'b0;
  endtask

  // Starts on a rising edge, returns on the edge that sees ray_done
  task automatic apply_row(input int idx);
    int errs;
    errs = 0;
    ray_origin <= rows[idx].origin;
    ray_dir <= rows[idx].dir;
    pixel_h_in <= rows[idx].h;
    pixel_v_in <= rows[idx].v;
    ray_valid <= 1'b1;
    @(posedge clk);
    ray_valid <= 1'b0;
    // Coordinate inputs move on while the ray is in flight
    pixel_h_in <= ~rows[idx].h;
    pixel_v_in <= ~rows[idx].v;
    do begin
      @(posedge clk);
    end while (ray_done !== 1'b1);
    assert (pixel_color === rows[idx].expected) else begin
      $display("** Error %s: pixel_color expected %h, actual %h",
               row_names[idx], rows[idx].expected, pixel_color);
      errs++;
    end
    assert (pixel_h_out === rows[idx].h) else begin
      $display("** Error %s: pixel_h_out expected %0d, actual %0d",
               row_names[idx], rows[idx].h, pixel_h_out);
      errs++;
    end
    assert (pixel_v_out === rows[idx].v) else begin
      $display("** Error %s: pixel_v_out expected %0d, actual %0d",
               row_names[idx], rows[idx].v, pixel_v_out);
      errs++;
    end
    report_test(row_names[idx], errs);
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    scene_we = 1'b0;
    scene_waddr = '0;
    scene_wdata = '0;
    ray_origin = '0;
    ray_dir = '0;
    ray_valid = 1'b0;
    pixel_h_in = '0;
    pixel_v_in = '0;
    row_count = 0;
    pass_count = 0;
    fail_count = 0;
    build_scene();
    build_table();
    wait (rst === 1'b0);
    @(posedge clk);
    check_idle_after_reset();
    load_scene();
    @(posedge clk);
    // Rays go in back to back
    for (int i = 0; i < row_count; i++) begin
      apply_row(i);
    end
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: ray_done never arrived within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
